//--- dv/csi2_rx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_rx_properties
(
  input logic clk_i,
  input logic srst_i,
  input logic hdr_valid_i,
  input logic ecc_err_i,
  input logic ecc_corr_i,
  input logic payload_valid_i,
  input logic pkt_done_i
);

int unsigned prop_fails = 0;
logic        pkt_open;

// Header seen whose packet has not ended yet
always_ff @( posedge clk_i )
  if( srst_i )
    pkt_open <= 1'b0;
  else
    if( pkt_done_i )
      pkt_open <= 1'b0;
    else
      if( hdr_valid_i )
        pkt_open <= 1'b1;

quiet_in_reset: assert property ( @( posedge clk_i )
  srst_i |=> !( hdr_valid_i || payload_valid_i || pkt_done_i || ecc_err_i || ecc_corr_i ) )
  else
    begin
      prop_fails++;
      $error( "Control outputs active during or right after reset" );
    end

done_is_pulse: assert property ( @( posedge clk_i ) disable iff( srst_i )
  pkt_done_i |=> !pkt_done_i )
  else
    begin
      prop_fails++;
      $error( "pkt_done_o held longer than one cycle" );
    end

corr_needs_err: assert property ( @( posedge clk_i ) disable iff( srst_i )
  ecc_corr_i |-> ecc_err_i )
  else
    begin
      prop_fails++;
      $error( "ecc_corr_o without ecc_err_o" );
    end

// Uncorrectable header stays flagged until the next header is taken
no_payload_on_drop: assert property ( @( posedge clk_i ) disable iff( srst_i )
  ( ecc_err_i && !ecc_corr_i ) |-> !payload_valid_i )
  else
    begin
      prop_fails++;
      $error( "Payload forwarded after an uncorrectable header" );
    end

hdr_after_done: assert property ( @( posedge clk_i ) disable iff( srst_i )
  hdr_valid_i |-> !pkt_open )
  else
    begin
      prop_fails++;
      $error( "New header before the previous packet ended" );
    end

endmodule

bind csi2_rx_top csi2_rx_properties rx_props (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .hdr_valid_i     ( hdr_valid_o     ),
  .ecc_err_i       ( ecc_err_o       ),
  .ecc_corr_i      ( ecc_corr_o      ),
  .payload_valid_i ( payload_valid_o ),
  .pkt_done_i      ( pkt_done_o      )
);

`default_nettype wire

//--- dv/csi2_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_rx_tb
  import csi2_pkg::*;
();

typedef struct packed {
  logic          corr;
  logic          err;
  logic          short_pkt;
  logic [1 : 0]  vc;
  logic [5 : 0]  dt;
  logic [15 : 0] wc;
} exp_hdr_t;

logic          clk;
logic          srst;
logic          rst_sampled;
logic          valid;
logic [31 : 0] data;
logic          hdr_valid;
logic [1 : 0]  hdr_vc;
logic [5 : 0]  hdr_dt;
logic [15 : 0] hdr_wc;
logic          ecc_err;
logic          ecc_corr;
logic          payload_valid;
logic [31 : 0] payload;
logic          pkt_done;

integer        seed = 32'h5d23;
int            value_errors = 0;
int            timeouts = 0;
int            prop_fails = 0;
exp_hdr_t      exp_hdr_q [$];
// Bit 32 marks the last word of the packet
logic [32 : 0] exp_pay_q [$];

csi2_rx_top DUT (
  .clk_i           ( clk           ),
  .srst_i          ( srst          ),
  .valid_i         ( valid         ),
  .data_i          ( data          ),
  .hdr_valid_o     ( hdr_valid     ),
  .hdr_vc_o        ( hdr_vc        ),
  .hdr_dt_o        ( hdr_dt        ),
  .hdr_wc_o        ( hdr_wc        ),
  .ecc_err_o       ( ecc_err       ),
  .ecc_corr_o      ( ecc_corr      ),
  .payload_valid_o ( payload_valid ),
  .payload_o       ( payload       ),
  .pkt_done_o      ( pkt_done      )
);

initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

function automatic int pick_below( input int n );
  return $unsigned( $random( seed ) ) % n;
endfunction

// Header ECC from the parity column of every set bit
function automatic logic [5 : 0] calc_ecc( input logic [23 : 0] bits );
  logic [5 : 0] ecc;
  ecc = '0;
  for( int i = 0; i < 24; i++ )
    if( bits[i] )
      ecc = ecc ^ ECC_COL[i];
  return ecc;
endfunction

task automatic log_mismatch( input string msg );
  value_errors++;
  $display( "CHECK FAILED at %0t: %s", $time, msg );
endtask

task automatic drive_word( input logic v, input logic [31 : 0] w );
  @( posedge clk );
  #1;
  valid = v;
  data  = w;
endtask

task automatic apply_reset();
  #1;
  srst  = 1'b1;
  valid = 1'b0;
  data  = '0;
  repeat( 5 ) @( posedge clk );
  #1;
  srst = 1'b0;
endtask

task automatic wait_pkt_done( output bit seen );
  int cycles;
  seen   = 1'b0;
  cycles = 0;
  while( !seen && cycles < 60 )
    begin
      @( negedge clk );
      seen = pkt_done;
      cycles++;
    end
  if( !seen )
    begin
      timeouts++;
      $display( "Timeout at %0t: pkt_done_o did not arrive within 60 cycles", $time );
    end
endtask

task automatic check_header();
  exp_hdr_t exp;
  assert( exp_hdr_q.size() > 0 )
  else
    log_mismatch( "hdr_valid_o with no header expected" );
  if( exp_hdr_q.size() > 0 )
    begin
      exp = exp_hdr_q.pop_front();
      assert( hdr_vc == exp.vc && hdr_dt == exp.dt && hdr_wc == exp.wc )
      else
        log_mismatch( $sformatf( "header vc %0d dt %h wc %h, expected vc %0d dt %h wc %h",
          hdr_vc, hdr_dt, hdr_wc, exp.vc, exp.dt, exp.wc ) );
      assert( ecc_err == exp.err && ecc_corr == exp.corr )
      else
        log_mismatch( $sformatf( "ecc flags err %b corr %b, expected err %b corr %b",
          ecc_err, ecc_corr, exp.err, exp.corr ) );
      assert( pkt_done == exp.short_pkt )
      else
        log_mismatch( $sformatf( "pkt_done_o %b with header, expected %b",
          pkt_done, exp.short_pkt ) );
    end
endtask

task automatic check_payload();
  logic [32 : 0] exp;
  assert( exp_pay_q.size() > 0 )
  else
    log_mismatch( "payload_valid_o with no payload expected" );
  if( exp_pay_q.size() > 0 )
    begin
      exp = exp_pay_q.pop_front();
      assert( payload == exp[31 : 0] )
      else
        log_mismatch( $sformatf( "payload %h, expected %h", payload, exp[31 : 0] ) );
      assert( pkt_done == exp[32] )
      else
        log_mismatch( $sformatf( "pkt_done_o %b on payload word, expected %b",
          pkt_done, exp[32] ) );
    end
endtask

// Reset as the DUT saw it at the last rising edge
always @( posedge clk )
  rst_sampled <= srst;

always @( negedge clk )
  if( rst_sampled )
    begin
      assert( !( hdr_valid || payload_valid || pkt_done || ecc_err || ecc_corr ) )
      else
        log_mismatch( "control outputs active during reset" );
    end
  else
    begin
      if( hdr_valid )
        check_header();
      if( payload_valid )
        check_payload();
    end

// Fault codes are 0 clean, 1 one data bit, 2 two data bits, 3 one ECC bit
task automatic send_packet( input bit long_pkt, input int fault );
  csi2_hdr_u     hdr;
  exp_hdr_t      exp;
  logic [31 : 0] sent;
  logic [31 : 0] word;
  int            n_words;
  int            pos_a;
  int            pos_b;
  bit            done_seen;
  hdr             = '0;
  hdr.long_hdr.vc = 2'( pick_below( 4 ) );
  if( long_pkt )
    begin
      hdr.long_hdr.dt = 6'( LONG_DT_MIN + pick_below( 48 ) );
      hdr.long_hdr.wc = 16'( pick_below( 40 ) );
      n_words         = ( hdr.long_hdr.wc + CRC_BYTES ) / 4;
      if( ( hdr.long_hdr.wc + CRC_BYTES ) % 4 != 0 )
        n_words++;
    end
  else
    begin
      hdr.short_hdr.dt         = 6'( pick_below( 16 ) );
      hdr.short_hdr.short_data = 16'( pick_below( 65536 ) );
      n_words                  = 0;
    end
  hdr.long_hdr.ecc = calc_ecc( hdr[23 : 0] );
  pos_a = pick_below( 24 );
  pos_b = ( pos_a + 1 + pick_below( 23 ) ) % 24;
  sent  = hdr;
  case( fault )
    1: sent[pos_a] = ~sent[pos_a];
    2:
      begin
        sent[pos_a] = ~sent[pos_a];
        sent[pos_b] = ~sent[pos_b];
      end
    3: sent[24 + pos_a % 6] = ~sent[24 + pos_a % 6];
  endcase
  if( fault < 2 )
    begin
      exp.corr      = ( fault == 1 );
      exp.err       = ( fault == 1 );
      exp.short_pkt = !long_pkt;
      exp.vc        = hdr.long_hdr.vc;
      exp.dt        = hdr.long_hdr.dt;
      exp.wc        = long_pkt ? hdr.long_hdr.wc : hdr.short_hdr.short_data;
      exp_hdr_q.push_back( exp );
    end
  drive_word( 1'b1, sent );
  for( int i = 0; i < n_words; i++ )
    begin
      word = $random( seed );
      if( fault < 2 )
        exp_pay_q.push_back( { 1'( i == n_words - 1 ), word } );
      drive_word( 1'b1, word );
    end
  drive_word( 1'b0, '0 );
  wait_pkt_done( done_seen );
  if( done_seen && fault >= 2 )
    begin
      assert( ecc_err && !ecc_corr )
      else
        log_mismatch( "uncorrectable header did not give ecc_err_o alone" );
    end
  @( posedge clk );
  assert( exp_hdr_q.size() == 0 && exp_pay_q.size() == 0 )
  else
    log_mismatch( $sformatf( "%0d headers and %0d payload words never appeared",
      exp_hdr_q.size(), exp_pay_q.size() ) );
  exp_hdr_q.delete();
  exp_pay_q.delete();
  repeat( 4 ) @( posedge clk );
endtask

initial
  begin
    srst  = 1'b1;
    valid = 1'b0;
    data  = '0;
    apply_reset();
    repeat( 3 ) send_packet( 1'b0, 0 );
    repeat( 3 ) send_packet( 1'b1, 0 );
    repeat( 3 ) send_packet( 1'b1, 1 );
    send_packet( 1'b0, 1 );
    send_packet( 1'b0, 0 );
    repeat( 2 )
      begin
        send_packet( 1'b1, 2 );
        send_packet( 1'b1, 0 );
      end
    repeat( 2 )
      begin
        send_packet( 1'b0, 3 );
        send_packet( 1'b0, 0 );
      end
    send_packet( 1'b1, 3 );
    send_packet( 1'b1, 1 );
    apply_reset();
    send_packet( 1'b1, 0 );
    prop_fails = DUT.rx_props.prop_fails;
    $display( "Error count: %0d value mismatches, %0d timeouts, %0d property failures",
      value_errors, timeouts, prop_fails );
    if( value_errors == 0 && timeouts == 0 && prop_fails == 0 )
      $display( "All checks passed" );
    else
      $display( "Checks failed" );
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/csi2_hamming_dec.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_hamming_dec
  import csi2_pkg::*;
(
  input  logic          clk_i,
  input  logic          srst_i,
  input  logic          valid_i,
  input  logic [31 : 0] data_i,
  csi2_word_if.dec      out_if
);

logic [5 : 0]  gen_parity;
logic [5 : 0]  syndrome;
logic [4 : 0]  fix_pos;
logic [31 : 0] data_d;
logic [31 : 0] fix_mask;
logic          valid_d;
logic          syn_nz_d;
logic          hdr_passed;
logic          hdr_word;
logic          fix_en;

// Parity over header bits 23:0
always_comb
  begin
    gen_parity = '0;
    for( int i = 0; i < 24; i++ )
      gen_parity = gen_parity ^ ( ECC_COL[i] & {6{data_i[i]}} );
  end

assign syndrome = gen_parity ^ data_i[29 : 24];

csi2_syndrome_lut syndrome_lut (
  .clk_i      ( clk_i    ),
  .srst_i     ( srst_i   ),
  .syndrome_i ( syndrome ),
  .bit_pos_o  ( fix_pos  )
);

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      valid_d  <= 1'b0;
      syn_nz_d <= 1'b0;
    end
  else
    begin
      valid_d  <= valid_i;
      syn_nz_d <= ( syndrome != 6'd0 );
    end

always_ff @( posedge clk_i )
  data_d <= data_i;

// First word of a packet, one cycle after input
assign hdr_word = valid_d && !hdr_passed;

always_ff @( posedge clk_i )
  if( srst_i )
    hdr_passed <= 1'b0;
  else
    if( hdr_word )
      hdr_passed <= 1'b1;
    else
      if( out_if.pkt_done )
        hdr_passed <= 1'b0;

// Only a data-bit column can be repaired
assign fix_en   = hdr_word && syn_nz_d && ( fix_pos != NO_FIX_POS );
assign fix_mask = 32'( fix_en ) << fix_pos;

always_ff @( posedge clk_i )
  out_if.data <= data_d ^ fix_mask;

always_ff @( posedge clk_i )
  if( srst_i )
    out_if.hdr_err <= 1'b0;
  else
    if( out_if.pkt_done )
      out_if.hdr_err <= 1'b0;
    else
      if( hdr_word && syn_nz_d )
        out_if.hdr_err <= 1'b1;

always_ff @( posedge clk_i )
  if( srst_i )
    out_if.hdr_fix <= 1'b0;
  else
    if( out_if.pkt_done )
      out_if.hdr_fix <= 1'b0;
    else
      if( fix_en )
        out_if.hdr_fix <= 1'b1;

// Valid is held through the pkt_done cycle
always_ff @( posedge clk_i )
  if( srst_i )
    out_if.valid <= 1'b0;
  else
    if( !out_if.pkt_done )
      out_if.valid <= valid_d;

endmodule

`default_nettype wire

//--- hw/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

  // Packet header word, seen as a long or a short packet
  typedef union packed {
    struct packed {
      logic [1:0]  rsvd;
      logic [5:0]  ecc;
      logic [15:0] wc;
      logic [1:0]  vc;
      logic [5:0]  dt;
    } long_hdr;
    struct packed {
      logic [1:0]  rsvd;
      logic [5:0]  ecc;
      logic [15:0] short_data;
      logic [1:0]  vc;
      logic [5:0]  dt;
    } short_hdr;
  } csi2_hdr_u;

  // Parity bits fed by each header bit, index 0 first
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0b, 6'h0d, 6'h0e,
    6'h13, 6'h15, 6'h16, 6'h19,
    6'h1a, 6'h1c, 6'h23, 6'h25,
    6'h26, 6'h29, 6'h2a, 6'h2c,
    6'h31, 6'h32, 6'h34, 6'h38,
    6'h1f, 6'h2f, 6'h37, 6'h3b
  };

  // Syndrome that matches no data bit
  localparam logic [4:0] NO_FIX_POS = 5'd31;

  localparam logic [5:0] LONG_DT_MIN = 6'h10;

  localparam int CRC_BYTES = 2;

  // Wide enough for ceil((0xffff + CRC_BYTES) / 4)
  localparam int PAYLOAD_CNT_W = 15;

  // Packet controller states
  localparam logic [1:0] PKT_IDLE    = 2'd0;
  localparam logic [1:0] PKT_PAYLOAD = 2'd1;
  localparam logic [1:0] PKT_DISCARD = 2'd2;

endpackage

`default_nettype wire

//--- hw/csi2_pkt_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_pkt_ctrl
  import csi2_pkg::*;
(
  input  logic          clk_i,
  input  logic          srst_i,
  csi2_word_if.ctrl     in_if,
  output logic          hdr_valid_o,
  output logic [1 : 0]  hdr_vc_o,
  output logic [5 : 0]  hdr_dt_o,
  output logic [15 : 0] hdr_wc_o,
  output logic          ecc_err_o,
  output logic          ecc_corr_o,
  output logic          payload_valid_o,
  output logic [31 : 0] payload_o,
  output logic          pkt_done_o
);

csi2_hdr_u                    hdr;
logic [1 : 0]                 state;
logic [PAYLOAD_CNT_W - 1 : 0] words_left;
logic [PAYLOAD_CNT_W - 1 : 0] long_words;
logic [16 : 0]                long_bytes;
logic                         is_long;
logic                         hdr_bad;
logic                         hdr_load;
logic                         pkt_done;

assign hdr     = in_if.data;
assign is_long = ( hdr.long_hdr.dt >= LONG_DT_MIN );
assign hdr_bad = in_if.hdr_err && !in_if.hdr_fix;

// Payload plus CRC bytes rounded up to whole words
assign long_bytes = {1'b0, hdr.long_hdr.wc} + 17'( CRC_BYTES + 3 );
assign long_words = ( long_bytes[16 : 2] == '0 ) ? PAYLOAD_CNT_W'( 1 ) : long_bytes[16 : 2];

assign hdr_load = ( state == PKT_IDLE ) && in_if.valid && !hdr_bad;

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      state           <= PKT_IDLE;
      words_left      <= '0;
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      pkt_done        <= 1'b0;
      ecc_err_o       <= 1'b0;
      ecc_corr_o      <= 1'b0;
    end
  else
    begin
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      pkt_done        <= 1'b0;
      case( state )
        PKT_IDLE:
          if( in_if.valid )
            begin
              ecc_err_o  <= in_if.hdr_err;
              ecc_corr_o <= in_if.hdr_fix;
              if( hdr_bad )
                state <= PKT_DISCARD;
              else
                begin
                  hdr_valid_o <= 1'b1;
                  if( is_long )
                    begin
                      words_left <= long_words;
                      state      <= PKT_PAYLOAD;
                    end
                  else
                    pkt_done <= 1'b1;
                end
            end
        PKT_PAYLOAD:
          if( in_if.valid )
            begin
              payload_valid_o <= 1'b1;
              words_left      <= words_left - 1'b1;
              // Last word including CRC
              if( words_left == PAYLOAD_CNT_W'( 1 ) )
                begin
                  pkt_done <= 1'b1;
                  state    <= PKT_IDLE;
                end
            end
        PKT_DISCARD:
          // Packet ends when the link goes idle
          if( !in_if.valid )
            begin
              pkt_done <= 1'b1;
              state    <= PKT_IDLE;
            end
        default:
          state <= PKT_IDLE;
      endcase
    end

always_ff @( posedge clk_i )
  if( hdr_load )
    begin
      hdr_vc_o <= hdr.long_hdr.vc;
      hdr_dt_o <= hdr.long_hdr.dt;
      // Short data sits in the same bits as the word count
      hdr_wc_o <= hdr.long_hdr.wc;
    end

always_ff @( posedge clk_i )
  if( ( state == PKT_PAYLOAD ) && in_if.valid )
    payload_o <= in_if.data;

assign in_if.pkt_done = pkt_done;
assign pkt_done_o     = pkt_done;

endmodule

`default_nettype wire

//--- hw/csi2_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_rx_top
(
  input  logic          clk_i,
  input  logic          srst_i,
  input  logic          valid_i,
  input  logic [31 : 0] data_i,
  output logic          hdr_valid_o,
  output logic [1 : 0]  hdr_vc_o,
  output logic [5 : 0]  hdr_dt_o,
  output logic [15 : 0] hdr_wc_o,
  output logic          ecc_err_o,
  output logic          ecc_corr_o,
  output logic          payload_valid_o,
  output logic [31 : 0] payload_o,
  output logic          pkt_done_o
);

// Decoded words from the ECC stage to the packet FSM
csi2_word_if word_if ();

csi2_hamming_dec hamming_dec (
  .clk_i   ( clk_i   ),
  .srst_i  ( srst_i  ),
  .valid_i ( valid_i ),
  .data_i  ( data_i  ),
  .out_if  ( word_if )
);

csi2_pkt_ctrl pkt_ctrl (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .in_if           ( word_if         ),
  .hdr_valid_o     ( hdr_valid_o     ),
  .hdr_vc_o        ( hdr_vc_o        ),
  .hdr_dt_o        ( hdr_dt_o        ),
  .hdr_wc_o        ( hdr_wc_o        ),
  .ecc_err_o       ( ecc_err_o       ),
  .ecc_corr_o      ( ecc_corr_o      ),
  .payload_valid_o ( payload_valid_o ),
  .payload_o       ( payload_o       ),
  .pkt_done_o      ( pkt_done_o      )
);

endmodule

`default_nettype wire

//--- hw/csi2_syndrome_lut.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_syndrome_lut
  import csi2_pkg::*;
(
  input  logic         clk_i,
  input  logic         srst_i,
  input  logic [5 : 0] syndrome_i,
  output logic [4 : 0] bit_pos_o
);

logic [4 : 0] pos_table [64];

// Header bit whose column equals the syndrome
function automatic logic [4 : 0] col_to_pos( input logic [5 : 0] syn );
  logic [4 : 0] pos;
  pos = NO_FIX_POS;
  for( int i = 0; i < 24; i++ )
    if( ECC_COL[i] == syn )
      pos = 5'( i );
  return pos;
endfunction

// Table contents are fixed at elaboration
for( genvar s = 0; s < 64; s++ )
  begin : g_table
    assign pos_table[s] = col_to_pos( 6'( s ) );
  end

always_ff @( posedge clk_i )
  if( srst_i )
    bit_pos_o <= NO_FIX_POS;
  else
    bit_pos_o <= pos_table[syndrome_i];

endmodule

`default_nettype wire

//--- hw/csi2_word_if.sv
`timescale 1ns/100ps
`default_nettype none

interface csi2_word_if;

  logic        valid;
  logic [31:0] data;
  // Header flags, held until pkt_done
  logic        hdr_err;
  logic        hdr_fix;
  logic        pkt_done;

  modport dec (
    output valid,
    output data,
    output hdr_err,
    output hdr_fix,
    input  pkt_done
  );

  modport ctrl (
    input  valid,
    input  data,
    input  hdr_err,
    input  hdr_fix,
    output pkt_done
  );

endinterface

`default_nettype wire

//--- project.f
hw/csi2_pkg.sv
hw/csi2_word_if.sv
hw/csi2_syndrome_lut.sv
hw/csi2_hamming_dec.sv
hw/csi2_pkt_ctrl.sv
hw/csi2_rx_top.sv
dv/csi2_rx_properties.sv
dv/csi2_rx_tb.sv
